// File: dv/axi_mem_model.sv
`timescale 1ns/100ps

module axi_mem_model import axis_rd_pkg::*; #(
   parameter int MEM_WORDS = 4096
) (
   input  logic   clk_i,
   input  logic   rst_n_i,
   input  addr_t  araddr_i,
   input  arlen_t arlen_i,
   input  logic   arvalid_i,
   output logic   arready_o,
   output word_t  rdata_o,
   output logic   rlast_o,
   output logic   rvalid_o,
   input  logic   rready_i,
   input  logic   ar_stall_i,
   input  logic   r_stall_i,
   input  logic   early_last_i
);

   localparam int IDX_W = $clog2(MEM_WORDS);

   // Loaded by the testbench before reset ends
   word_t            mem [MEM_WORDS];
   logic             busy_q = 1'b0;
   logic             rvalid_q = 1'b0;
   logic [IDX_W-1:0] idx_q = '0;
   logic [8:0]       left_q = '0;
   logic             beat_acc;

   // One burst at a time
   assign arready_o = !busy_q && !ar_stall_i;
   assign rvalid_o  = rvalid_q;
   assign rdata_o   = mem[idx_q];
   assign beat_acc  = rvalid_q && rready_i;

   // Fault mode ends the burst one beat short
   assign rlast_o = (left_q == 9'd1) || (early_last_i && (left_q == 9'd2));

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         busy_q   <= 1'b0;
         rvalid_q <= 1'b0;
      end else if (!busy_q) begin
         if (arvalid_i && arready_o) begin
            busy_q <= 1'b1;
            idx_q  <= araddr_i[IDX_W+1:2];
            left_q <= 9'(arlen_i) + 9'd1;
         end
      end else if (beat_acc && rlast_o) begin
         busy_q   <= 1'b0;
         rvalid_q <= 1'b0;
      end else if (beat_acc) begin
         idx_q    <= idx_q + IDX_W'(1);
         left_q   <= left_q - 9'd1;
         rvalid_q <= !r_stall_i;
      end else if (!rvalid_q) begin
         rvalid_q <= !r_stall_i;
      end
   end

endmodule

// File: dv/tb_axis_rd_dma.sv
`timescale 1ns/100ps
`include "axis_rd_params.svh"

module tb_axis_rd_dma import axis_rd_pkg::*; ();

   localparam logic [31:0] SEED = 32'hf20608fd;
   localparam int MEM_WORDS = 4096;
   // All words moved by the tests
   localparam int TOTAL_WORDS = 205;
   localparam int LIMIT_CYCLES = TOTAL_WORDS * 40 + 1000;

   // Names match the DUT ports
   logic   clk_i = 1'b0;
   logic   rst_n_i = 1'b0;
   logic   cfg_valid_i = 1'b0;
   addr_t  cfg_addr_i = '0;
   len_t   cfg_len_i = '0;
   logic   axis_ready_i = 1'b1;
   logic   cfg_ready_o;
   logic   done_o;
   logic   err_o;
   addr_t  m_axi_araddr_o;
   arlen_t m_axi_arlen_o;
   logic   m_axi_arvalid_o;
   logic   m_axi_arready_i;
   word_t  m_axi_rdata_i;
   logic   m_axi_rlast_i;
   logic   m_axi_rvalid_i;
   logic   m_axi_rready_o;
   word_t  axis_data_o;
   logic   axis_valid_o;

   logic        stall_en = 1'b0;
   logic        ar_stall = 1'b0;
   logic        r_stall = 1'b0;
   logic        early_last = 1'b0;
   logic [31:0] stall_rnd = SEED;

   word_t  ref_mem [MEM_WORDS];
   word_t  exp_words [$];
   addr_t  exp_addr [$];
   arlen_t exp_arlen [$];
   int     ar_cnt = 0;
   int     done_cnt = 0;
   int     data_errs = 0;
   int     addr_errs = 0;
   int     arlen_errs = 0;
   int     count_errs = 0;
   int     flag_errs = 0;
   int     other_errs = 0;

   axis_rd_dma dut (.*);

   axi_mem_model #(.MEM_WORDS(MEM_WORDS)) u_mem (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .araddr_i     (m_axi_araddr_o),
      .arlen_i      (m_axi_arlen_o),
      .arvalid_i    (m_axi_arvalid_o),
      .arready_o    (m_axi_arready_i),
      .rdata_o      (m_axi_rdata_i),
      .rlast_o      (m_axi_rlast_i),
      .rvalid_o     (m_axi_rvalid_i),
      .rready_i     (m_axi_rready_o),
      .ar_stall_i   (ar_stall),
      .r_stall_i    (r_stall),
      .early_last_i (early_last)
   );

   always #10 clk_i = ~clk_i;

   function automatic logic [31:0] lcg_step(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // Roughly one stall cycle in four on each channel
   always @(posedge clk_i) begin
      stall_rnd = lcg_step(stall_rnd);
      ar_stall     <= stall_en && (stall_rnd[31:30] == 2'b00);
      r_stall      <= stall_en && (stall_rnd[29:28] == 2'b00);
      axis_ready_i <= !(stall_en && (stall_rnd[27:26] == 2'b00));
   end

   task automatic word_equal(input word_t got, input word_t exp, input string what);
      if (got !== exp) begin
         data_errs++;
         $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic addr_equal(input addr_t got, input addr_t exp, input string what);
      if (got !== exp) begin
         addr_errs++;
         $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic arlen_equal(input arlen_t got, input arlen_t exp, input string what);
      if (got !== exp) begin
         arlen_errs++;
         $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic count_equal(input len_t got, input len_t exp, input string what);
      if (got !== exp) begin
         count_errs++;
         $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic flag_equal(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         flag_errs++;
         $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   // Monitors sample mid cycle, away from the driving edge
   always @(negedge clk_i) begin
      if (axis_valid_o && axis_ready_i) begin
         if (exp_words.size() == 0) begin
            other_errs++;
            $display("stream beat at %0t with no data expected", $time);
         end else begin
            word_equal(axis_data_o, exp_words.pop_front(), "stream data");
         end
      end
      if (m_axi_arvalid_o && m_axi_arready_i) begin
         ar_cnt++;
         if ({20'd0, m_axi_araddr_o[11:0]} + ((32'(m_axi_arlen_o) + 32'd1) << 2) > 32'd4096) begin
            other_errs++;
            $display("read burst at %0t crosses a 4 KB boundary", $time);
         end
         if (exp_addr.size() == 0) begin
            other_errs++;
            $display("read burst at %0t that no transfer calls for", $time);
         end else begin
            addr_equal(m_axi_araddr_o, exp_addr.pop_front(), "araddr");
            arlen_equal(m_axi_arlen_o, exp_arlen.pop_front(), "arlen");
         end
      end
      if (done_o) begin
         done_cnt++;
      end
   end

   initial begin
      repeat (LIMIT_CYCLES) @(posedge clk_i);
      $display("watchdog expired after %0d cycles, a transfer never finished", LIMIT_CYCLES);
      $display("TB FAILED");
      $finish;
   end

   task automatic fill_memory();
      logic [31:0] rnd;
      rnd = SEED;
      for (int i = 0; i < MEM_WORDS; i++) begin
         rnd = lcg_step(rnd);
         // Byte address mixed in so no two words alias
         ref_mem[i] = rnd ^ (32'(i) << 2);
         u_mem.mem[i] = ref_mem[i];
      end
   endtask

   task automatic predict_bursts(input addr_t addr, input int words, input logic early,
                                 output int bursts);
      addr_t cur;
      int    left;
      int    beats;
      int    shown;
      cur = addr;
      left = words;
      bursts = 0;
      while (left > 0) begin
         // Capped by the remainder, the burst limit and the 4 KB page
         beats = (left < `RD_MAX_BURST) ? left : `RD_MAX_BURST;
         if (beats > (4096 - int'(cur[11:0])) / 4) begin
            beats = (4096 - int'(cur[11:0])) / 4;
         end
         exp_addr.push_back(cur);
         exp_arlen.push_back(arlen_t'(beats - 1));
         // Early rlast drops the last beat of the burst
         shown = (early && beats > 1) ? beats - 1 : beats;
         for (int i = 0; i < shown; i++) begin
            exp_words.push_back(ref_mem[(int'(cur[31:2]) + i) % MEM_WORDS]);
         end
         cur = cur + addr_t'(beats * 4);
         left = left - beats;
         bursts++;
      end
   endtask

   task automatic send_config(input addr_t addr, input len_t words);
      @(posedge clk_i);
      cfg_valid_i <= 1'b1;
      cfg_addr_i  <= addr;
      cfg_len_i   <= words;
      do begin
         @(negedge clk_i);
      end while (!cfg_ready_o);
      @(posedge clk_i);
      cfg_valid_i <= 1'b0;
   endtask

   task automatic transfer(input addr_t addr, input int words, input logic early);
      int bursts;
      int ar_before;
      int done_before;
      ar_before = ar_cnt;
      done_before = done_cnt;
      predict_bursts(addr, words, early, bursts);
      send_config(addr, len_t'(words));
      do begin
         @(posedge clk_i);
      end while (done_cnt == done_before);
      repeat (3) @(negedge clk_i);
      count_equal(len_t'(exp_words.size()), '0, "words never streamed");
      count_equal(len_t'(ar_cnt - ar_before), len_t'(bursts), "read bursts");
      count_equal(len_t'(done_cnt - done_before), len_t'(1), "done pulses");
   endtask

   task automatic reset_values();
      flag_equal(cfg_ready_o, 1'b1, "cfg_ready after reset");
      flag_equal(m_axi_arvalid_o, 1'b0, "arvalid after reset");
      flag_equal(m_axi_rready_o, 1'b0, "rready after reset");
      flag_equal(axis_valid_o, 1'b0, "stream valid after reset");
      flag_equal(done_o | err_o, 1'b0, "done or err after reset");
   endtask

   task automatic back_pressure();
      @(posedge clk_i);
      stall_en <= 1'b1;
      transfer(32'h0000_2f40, 100, 1'b0);
      transfer(32'h0000_1ffc, 37, 1'b0);
      @(posedge clk_i);
      stall_en <= 1'b0;
   endtask

   task automatic zero_length();
      int ar_before;
      int done_before;
      ar_before = ar_cnt;
      done_before = done_cnt;
      send_config(32'h0000_0200, '0);
      repeat (20) begin
         @(negedge clk_i);
         flag_equal(cfg_ready_o, 1'b1, "cfg_ready with zero length");
         flag_equal(axis_valid_o, 1'b0, "stream valid with zero length");
      end
      count_equal(len_t'(ar_cnt - ar_before), '0, "read bursts with zero length");
      count_equal(len_t'(done_cnt - done_before), '0, "done pulses with zero length");
   endtask

   task automatic rlast_fault();
      flag_equal(err_o, 1'b0, "err before the fault");
      @(posedge clk_i);
      early_last <= 1'b1;
      transfer(32'h0000_0800, 5, 1'b1);
      flag_equal(err_o, 1'b1, "err after early rlast");
      @(posedge clk_i);
      early_last <= 1'b0;
      transfer(32'h0000_0900, 8, 1'b0);
      flag_equal(err_o, 1'b1, "err held after the fault");
   endtask

   initial begin
      fill_memory();
      repeat (8) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(negedge clk_i);
      reset_values();
      // Short, split and page boundary cases
      transfer(32'h0000_0100, 5, 1'b0);
      transfer(32'h0000_0400, 40, 1'b0);
      transfer(32'h0000_0ff4, 10, 1'b0);
      back_pressure();
      zero_length();
      rlast_fault();
      $display("errors: data %0d, address %0d, arlen %0d, count %0d, flag %0d, other %0d",
               data_errs, addr_errs, arlen_errs, count_errs, flag_errs, other_errs);
      if (data_errs + addr_errs + arlen_errs + count_errs + flag_errs + other_errs == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// File: hw/axi_rd_if.sv
`timescale 1ns/100ps

interface axi_rd_if import axis_rd_pkg::*; ();

   // AR channel
   addr_t  araddr;
   arlen_t arlen;
   logic   arvalid;
   logic   arready;

   // R channel
   word_t  rdata;
   logic   rlast;
   logic   rvalid;
   logic   rready;

   modport mst (
      output araddr,
      output arlen,
      output arvalid,
      input  arready,
      input  rdata,
      input  rlast,
      input  rvalid,
      output rready
   );

   // Passive view for beat tracking
   modport mon (
      input araddr,
      input arlen,
      input arvalid,
      input arready,
      input rdata,
      input rlast,
      input rvalid,
      input rready
   );

endinterface

// File: hw/axis_rd_dma.sv
`timescale 1ns/100ps

module axis_rd_dma import axis_rd_pkg::*; (
   input  logic   clk_i,
   input  logic   rst_n_i,

   input  logic   cfg_valid_i,
   input  addr_t  cfg_addr_i,
   input  len_t   cfg_len_i,
   output logic   cfg_ready_o,
   output logic   done_o,
   output logic   err_o,

   output addr_t  m_axi_araddr_o,
   output arlen_t m_axi_arlen_o,
   output logic   m_axi_arvalid_o,
   input  logic   m_axi_arready_i,
   input  word_t  m_axi_rdata_i,
   input  logic   m_axi_rlast_i,
   input  logic   m_axi_rvalid_i,
   output logic   m_axi_rready_o,

   output word_t  axis_data_o,
   output logic   axis_valid_o,
   input  logic   axis_ready_i
);

   axi_rd_if axi_bus ();

   logic   load;
   logic   plan;
   logic   burst_done;
   beats_t plan_beats;
   addr_t  cur_addr;
   len_t   remain;
   arlen_t cur_arlen;

   // Slave side inputs into the bundle
   assign axi_bus.arready = m_axi_arready_i;
   assign axi_bus.rdata   = m_axi_rdata_i;
   assign axi_bus.rlast   = m_axi_rlast_i;
   assign axi_bus.rvalid  = m_axi_rvalid_i;

   // Address and length come from the tracker registers
   assign axi_bus.araddr = cur_addr;
   assign axi_bus.arlen  = cur_arlen;

   assign m_axi_araddr_o  = axi_bus.araddr;
   assign m_axi_arlen_o   = axi_bus.arlen;
   assign m_axi_arvalid_o = axi_bus.arvalid;
   assign m_axi_rready_o  = axi_bus.rready;
   assign axis_data_o     = axi_bus.rdata;

   burst_planner u_planner (
      .addr_i   (cur_addr),
      .remain_i (remain),
      .beats_o  (plan_beats)
   );

   rd_addr_tracker u_tracker (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .load_i       (load),
      .cfg_addr_i   (cfg_addr_i),
      .cfg_len_i    (cfg_len_i),
      .plan_i       (plan),
      .beats_i      (plan_beats),
      .burst_done_i (burst_done),
      .addr_o       (cur_addr),
      .remain_o     (remain),
      .arlen_o      (cur_arlen)
   );

   rd_beat_counter u_beat_cnt (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .axi          (axi_bus.mon),
      .arlen_i      (cur_arlen),
      .burst_done_o (burst_done),
      .err_o        (err_o)
   );

   rd_ctrl u_ctrl (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .cfg_valid_i  (cfg_valid_i),
      .cfg_len_i    (cfg_len_i),
      .cfg_ready_o  (cfg_ready_o),
      .remain_i     (remain),
      .burst_done_i (burst_done),
      .load_o       (load),
      .plan_o       (plan),
      .done_o       (done_o),
      .axi          (axi_bus.mst),
      .axis_valid_o (axis_valid_o),
      .axis_ready_i (axis_ready_i)
   );

endmodule

// File: hw/axis_rd_params.svh
`ifndef AXIS_RD_PARAMS_SVH
`define AXIS_RD_PARAMS_SVH

// Byte address width
`define RD_ADDR_W 32

// Stream and AXI data width of one 4-byte word per beat
`define RD_DATA_W 32

// Transfer length field, counted in words
`define RD_LEN_W 16

// Largest burst issued on the AR channel
`define RD_MAX_BURST 16

// AXI4 arlen field
`define RD_ARLEN_W 8

`endif

// File: hw/axis_rd_pkg.sv
`include "axis_rd_params.svh"

package axis_rd_pkg;

   // Byte address on the AXI side
   typedef logic [`RD_ADDR_W-1:0] addr_t;

   // One data beat
   typedef logic [`RD_DATA_W-1:0] word_t;

   // Word count of a whole transfer
   typedef logic [`RD_LEN_W-1:0] len_t;

   // Beats in one burst from 0 up to the burst limit inclusive
   typedef logic [$clog2(`RD_MAX_BURST + 1)-1:0] beats_t;

   // AXI length field holding beats minus one
   typedef logic [`RD_ARLEN_W-1:0] arlen_t;

   // Controller states
   typedef enum logic [1:0] {
      RD_IDLE  = 2'd0,
      RD_PLAN  = 2'd1,
      RD_ISSUE = 2'd2,
      RD_DATA  = 2'd3
   } rd_state_e;

endpackage

// File: hw/burst_planner.sv
`timescale 1ns/100ps
`include "axis_rd_params.svh"

module burst_planner import axis_rd_pkg::*; (
   input  addr_t  addr_i,
   input  len_t   remain_i,
   output beats_t beats_o
);

   localparam int unsigned PAGE_BYTES = 4096;
   localparam len_t        MAX_BURST  = len_t'(`RD_MAX_BURST);

   logic [12:0] page_left_bytes;
   len_t        page_left_words;
   len_t        capped;
   len_t        chosen;

   // Bytes up to the next 4 KB boundary (4 to 4096)
   assign page_left_bytes = 13'(PAGE_BYTES) - {1'b0, addr_i[11:0]};

   // Word aligned, so the low two bits are always zero
   assign page_left_words = len_t'(page_left_bytes[12:2]);

   always_comb begin
      if (remain_i < MAX_BURST) begin
         capped = remain_i;
      end else begin
         capped = MAX_BURST;
      end
   end

   always_comb begin
      if (page_left_words < capped) begin
         chosen = page_left_words;
      end else begin
         chosen = capped;
      end
   end

   // chosen never exceeds the burst limit, so it fits
   assign beats_o = beats_t'(chosen);

endmodule

// File: hw/rd_addr_tracker.sv
`timescale 1ns/100ps

module rd_addr_tracker import axis_rd_pkg::*; (
   input  logic   clk_i,
   input  logic   rst_n_i,
   input  logic   load_i,
   input  addr_t  cfg_addr_i,
   input  len_t   cfg_len_i,
   input  logic   plan_i,
   input  beats_t beats_i,
   input  logic   burst_done_i,
   output addr_t  addr_o,
   output len_t   remain_o,
   output arlen_t arlen_o
);

   addr_t  addr_q;
   len_t   remain_q;
   arlen_t arlen_q;
   addr_t  burst_words;
   addr_t  next_addr;

   // Step past the burst that just finished
   assign burst_words = addr_t'(arlen_q) + addr_t'(1);
   assign next_addr   = addr_q + (burst_words << 2);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         remain_q <= '0;
      end else if (load_i) begin
         remain_q <= cfg_len_i;
      end else if (plan_i) begin
         remain_q <= remain_q - len_t'(beats_i);
      end
   end

   always_ff @(posedge clk_i) begin
      if (load_i) begin
         addr_q <= cfg_addr_i;
      end else if (burst_done_i) begin
         addr_q <= next_addr;
      end
   end

   always_ff @(posedge clk_i) begin
      if (plan_i) begin
         arlen_q <= arlen_t'(beats_i) - arlen_t'(1);
      end
   end

   assign addr_o   = addr_q;
   assign remain_o = remain_q;
   assign arlen_o  = arlen_q;

endmodule

// File: hw/rd_beat_counter.sv
`timescale 1ns/100ps

module rd_beat_counter import axis_rd_pkg::*; (
   input  logic   clk_i,
   input  logic   rst_n_i,
   axi_rd_if.mon  axi,
   input  arlen_t arlen_i,
   output logic   burst_done_o,
   output logic   err_o
);

   arlen_t beat_cnt;
   logic   beat_acc;
   logic   at_planned_last;
   logic   mismatch;
   logic   err_q;

   assign beat_acc        = axi.rvalid && axi.rready;
   assign at_planned_last = (beat_cnt == arlen_i);

   // Early rlast, or no rlast on the planned final beat
   assign mismatch = beat_acc && (axi.rlast != at_planned_last);

   // A missing rlast still closes the burst so the FSM moves on
   assign burst_done_o = beat_acc && (axi.rlast || at_planned_last);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         beat_cnt <= '0;
      end else if (burst_done_o) begin
         beat_cnt <= '0;
      end else if (beat_acc) begin
         beat_cnt <= beat_cnt + arlen_t'(1);
      end
   end

   // Sticky until reset
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         err_q <= 1'b0;
      end else if (mismatch) begin
         err_q <= 1'b1;
      end
   end

   assign err_o = err_q;

endmodule

// File: hw/rd_ctrl.sv
`timescale 1ns/100ps

module rd_ctrl import axis_rd_pkg::*; (
   input  logic  clk_i,
   input  logic  rst_n_i,
   input  logic  cfg_valid_i,
   input  len_t  cfg_len_i,
   output logic  cfg_ready_o,
   input  len_t  remain_i,
   input  logic  burst_done_i,
   output logic  load_o,
   output logic  plan_o,
   output logic  done_o,
   axi_rd_if.mst axi,
   output logic  axis_valid_o,
   input  logic  axis_ready_i
);

   rd_state_e state;
   rd_state_e state_nxt;
   logic      in_data;
   logic      last_burst_end;
   logic      done_q;

   assign in_data        = (state == RD_DATA);
   assign last_burst_end = in_data && burst_done_i && (remain_i == '0);

   always_comb begin
      state_nxt = state;
      case (state)
         RD_IDLE: begin
            // Zero length is taken but starts nothing
            if (cfg_valid_i && (cfg_len_i != '0)) begin
               state_nxt = RD_PLAN;
            end
         end
         RD_PLAN: begin
            state_nxt = RD_ISSUE;
         end
         RD_ISSUE: begin
            if (axi.arready) begin
               state_nxt = RD_DATA;
            end
         end
         RD_DATA: begin
            if (burst_done_i) begin
               if (remain_i == '0) begin
                  state_nxt = RD_IDLE;
               end else begin
                  state_nxt = RD_PLAN;
               end
            end
         end
         default: begin
            state_nxt = RD_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state <= RD_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // One cycle pulse on the way back to idle
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         done_q <= 1'b0;
      end else begin
         done_q <= last_burst_end;
      end
   end

   assign cfg_ready_o = (state == RD_IDLE);
   assign load_o      = cfg_ready_o && cfg_valid_i;
   assign plan_o      = (state == RD_PLAN);
   assign done_o      = done_q;

   assign axi.arvalid = (state == RD_ISSUE);

   // Stream stalls go straight back to the R channel
   assign axi.rready   = in_data && axis_ready_i;
   assign axis_valid_o = in_data && axi.rvalid;

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_axis_rd_dma -f vlog.f

out=$(./obj_dir/Vtb_axis_rd_dma)
echo "$out"

if echo "$out" | grep -qx "TB PASSED"; then
   exit 0
fi
exit 1

// File: vlog.f
+incdir+hw
hw/axis_rd_pkg.sv
hw/axi_rd_if.sv
hw/burst_planner.sv
hw/rd_addr_tracker.sv
hw/rd_beat_counter.sv
hw/rd_ctrl.sv
hw/axis_rd_dma.sv
dv/axi_mem_model.sv
dv/tb_axis_rd_dma.sv
